// File: pf_cfg.svh
/*
 * Configuration macros of the prefetch controller
 * FIFO depth, count width, fetch address width and word size
 */
`ifndef PF_CFG_SVH
`define PF_CFG_SVH

// Prefetch FIFO depth
// Also caps the FIFO words plus outstanding transactions
`define PF_DEPTH 4

// Width of every count value, must be able to hold PF_DEPTH
`define PF_CNT_W 3

// Fetch address width
`define PF_ADDR_W 32

// Bytes per fetched word, sets increment and alignment
`define PF_WORD_BYTES 4

`endif

// File: pf_pkg.sv
/*
 * Shared types of the prefetch controller
 * Address state enum, fetch address and count types
 */
`default_nettype none

`include "pf_cfg.svh"

package pf_pkg;

  // Address generator state
  typedef enum logic {
    PF_IDLE        = 1'b0,
    PF_BRANCH_WAIT = 1'b1
  } pf_state_e;

  // Fetch address
  typedef logic [`PF_ADDR_W-1:0] pf_addr_t;

  // Outstanding, flush and FIFO counts
  typedef logic [`PF_CNT_W-1:0] pf_cnt_t;

endpackage

`default_nettype wire

// File: pf_evt_if.sv
/*
 * Flow event bundle shared by the prefetch logic blocks
 * Branch, loop jump, response, acceptance and outstanding count
 */
`timescale 1ns/1ps
`default_nettype none

interface pf_evt_if;
  import pf_pkg::*;

  // Taken branch from the fetch stage
  logic    branch;
  // Hardware-loop jump
  logic    hwlp_jump;
  // One-cycle response strobe from the bus
  logic    resp_valid;
  // Request accepted by the bus this cycle
  logic    accept;
  // Outstanding transactions, registered
  pf_cnt_t out_cnt;

  // Transaction tracker owns acceptance and the outstanding count
  modport tracker (
    input  branch,
    input  hwlp_jump,
    input  resp_valid,
    output accept,
    output out_cnt
  );

  // Address generator only needs the flow changes and acceptance
  modport addr (
    input branch,
    input hwlp_jump,
    input accept
  );

  // Flush control watches everything
  modport flush (
    input branch,
    input hwlp_jump,
    input resp_valid,
    input accept,
    input out_cnt
  );

endinterface

`default_nettype wire

// File: pf_txn_tracker.sv
/*
 * Transaction tracker of the prefetch controller
 * Request admission, acceptance strobe, outstanding counter, busy flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "pf_cfg.svh"

module pf_txn_tracker (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  logic            trans_ready_i,
  input  pf_pkg::pf_cnt_t fifo_cnt_i,
  output logic            trans_valid_o,
  output logic            busy_o,
  pf_evt_if.tracker       evt
);
  import pf_pkg::*;

  // One extra bit so FIFO words plus outstanding never wraps
  localparam int unsigned SUM_W = `PF_CNT_W + 1;

  pf_cnt_t          cnt_q;
  pf_cnt_t          cnt_d;
  pf_cnt_t          fifo_cnt_masked;
  logic [SUM_W-1:0] occupancy;
  logic             count_up;
  logic             count_down;

  ////////////////////////////////////////////////////////////
  // Admission
  ////////////////////////////////////////////////////////////

  // A branch or loop jump empties the FIFO anyway
  // so its words do not block the new request
  assign fifo_cnt_masked = (evt.branch || evt.hwlp_jump) ? '0 : fifo_cnt_i;

  // Words that will land in the FIFO, stored and in flight
  assign occupancy = {1'b0, fifo_cnt_masked} + {1'b0, cnt_q};

  // Only request while the FIFO is sure to have room for the response
  assign trans_valid_o = req_i && (occupancy < SUM_W'(`PF_DEPTH));

  assign count_up   = trans_valid_o && trans_ready_i;
  assign count_down = evt.resp_valid;

  assign evt.accept  = count_up;
  assign evt.out_cnt = cnt_q;

  // Busy while anything is in flight or about to be
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + pf_cnt_t'(1);
      2'b01:   cnt_d = cnt_q - pf_cnt_t'(1);
      // Accept and response together cancel out
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: pf_addr_gen.sv
/*
 * Transaction address generator of the prefetch controller
 * Branch-wait state machine and transaction address register
 */
`timescale 1ns/1ps
`default_nettype none

`include "pf_cfg.svh"

module pf_addr_gen (
  input  logic             clk,
  input  logic             rst_n,
  input  pf_pkg::pf_addr_t branch_addr_i,
  input  pf_pkg::pf_addr_t hwlp_target_i,
  output pf_pkg::pf_addr_t trans_addr_o,
  pf_evt_if.addr           evt
);
  import pf_pkg::*;

  // Byte offset bits inside a word
  localparam pf_addr_t WORD_MASK = pf_addr_t'(`PF_WORD_BYTES - 1);
  // Step between sequential fetches
  localparam pf_addr_t WORD_INCR = pf_addr_t'(`PF_WORD_BYTES);

  pf_state_e state_q;
  pf_state_e state_d;
  pf_addr_t  addr_q;
  pf_addr_t  branch_aligned;
  pf_addr_t  addr_incr;
  logic      addr_load;

  // Only whole words are fetched
  assign branch_aligned = branch_addr_i & ~WORD_MASK;
  assign addr_incr      = (addr_q & ~WORD_MASK) + WORD_INCR;

  // Capture the presented address on any flow change or acceptance
  assign addr_load = evt.branch || evt.hwlp_jump || evt.accept;

  ////////////////////////////////////////////////////////////
  // Address FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    trans_addr_o = addr_q;

    case (state_q)
      PF_IDLE: begin
        // Branch wins over the loop jump
        // e.g. an interrupt taken on the last loop instruction
        if (evt.branch) begin
          trans_addr_o = branch_aligned;
        end else if (evt.hwlp_jump) begin
          trans_addr_o = hwlp_target_i;
        end else begin
          trans_addr_o = addr_incr;
        end
        // Target not taken by the bus yet, keep replaying it
        if ((evt.branch || evt.hwlp_jump) && !evt.accept) begin
          state_d = PF_BRANCH_WAIT;
        end
      end

      PF_BRANCH_WAIT: begin
        // Replay the held target unless a newer branch replaces it
        trans_addr_o = evt.branch ? branch_aligned : addr_q;
        // Target accepted, sequential prefetch resumes
        if (evt.accept) begin
          state_d = PF_IDLE;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PF_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        addr_q <= trans_addr_o;
      end
    end
  end

endmodule

`default_nettype wire

// File: pf_flush_ctrl.sv
/*
 * Response flush and FIFO control of the prefetch controller
 * Flush counter, delayed loop flush, FIFO strobes and fetch-valid
 */
`timescale 1ns/1ps
`default_nettype none

module pf_flush_ctrl (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      fetch_ready_i,
  input  logic      fifo_empty_i,
  output logic      fetch_valid_o,
  output logic      fifo_push_o,
  output logic      fifo_pop_o,
  output logic      fifo_flush_o,
  output logic      fifo_flush_but_first_o,
  pf_evt_if.flush   evt
);
  import pf_pkg::*;

  pf_cnt_t flush_cnt_q;
  pf_cnt_t flush_cnt_d;
  // Outstanding responses to drop once the loop end word returns
  pf_cnt_t delay_cnt_q;
  logic    delay_armed_q;
  logic    fifo_valid;
  logic    flushing;
  logic    hwlp_flush_now;
  logic    hwlp_flush_arm;
  logic    delay_fire;

  assign fifo_valid = !fifo_empty_i;

  // Responses in this window belong to the discarded path
  assign flushing = evt.branch || (flush_cnt_q != '0);

  ////////////////////////////////////////////////////////////
  // Fetch and FIFO strobes
  ////////////////////////////////////////////////////////////

  // Valid from the FIFO head or straight from the bus
  assign fetch_valid_o = (fifo_valid || evt.resp_valid) && !flushing;

  // Bypass to fetch when the FIFO is empty and fetch takes it,
  // otherwise the response goes into the FIFO
  assign fifo_push_o = evt.resp_valid && (fifo_valid || !fetch_ready_i) && !flushing;
  assign fifo_pop_o  = fifo_valid && fetch_ready_i;

  // Loop jump keeps the head word when it is not being consumed,
  // that word is the loop end instruction
  assign fifo_flush_o           = evt.branch || (evt.hwlp_jump && fifo_valid && fifo_pop_o);
  assign fifo_flush_but_first_o = evt.hwlp_jump && fifo_valid && !fifo_pop_o;

  ////////////////////////////////////////////////////////////
  // Loop jump flush decision
  ////////////////////////////////////////////////////////////

  // Loop end word already here, in the FIFO or on the bus
  assign hwlp_flush_now = evt.hwlp_jump && !(fifo_empty_i && !evt.resp_valid);

  // Loop end word still in flight, flush after it arrives
  assign hwlp_flush_arm = evt.hwlp_jump && fifo_empty_i && !evt.resp_valid;

  assign delay_fire = delay_armed_q && evt.resp_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_armed_q <= 1'b0;
      delay_cnt_q   <= '0;
    end else if (evt.branch) begin
      // Branch flushes everything, pending loop flush is moot
      delay_armed_q <= 1'b0;
      delay_cnt_q   <= '0;
    end else if (hwlp_flush_arm) begin
      delay_armed_q <= 1'b1;
      // Spare the oldest outstanding one, it is the loop end word
      delay_cnt_q   <= evt.out_cnt - pf_cnt_t'(1);
    end else if (delay_fire) begin
      delay_armed_q <= 1'b0;
      delay_cnt_q   <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response flush counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (evt.branch || hwlp_flush_now) begin
      // Everything still outstanding is on the wrong path
      flush_cnt_d = evt.out_cnt;
      // A response landing now is already dropped by the strobes
      if (evt.resp_valid && (evt.out_cnt != '0)) begin
        flush_cnt_d = evt.out_cnt - pf_cnt_t'(1);
      end
    end else if (delay_fire) begin
      // Lower priority than a branch, interrupts win over loops
      flush_cnt_d = delay_cnt_q;
    end else if (evt.resp_valid && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - pf_cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_cnt_q <= '0;
    end else begin
      flush_cnt_q <= flush_cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: pf_prefetch_ctrl.sv
/*
 * Instruction prefetch controller top level
 * Event bundle, transaction tracker, address generator, flush control
 */
`timescale 1ns/1ps
`default_nettype none

`include "pf_cfg.svh"

module pf_prefetch_ctrl (
  input  logic             clk,
  input  logic             rst_n,

  // Fetch stage side
  input  logic             req_i,
  input  logic             branch_i,
  input  pf_pkg::pf_addr_t branch_addr_i,
  output logic             busy_o,

  // Hardware loop
  input  logic             hwlp_jump_i,
  input  pf_pkg::pf_addr_t hwlp_target_i,

  // Bus transaction request
  output logic             trans_valid_o,
  input  logic             trans_ready_i,
  output pf_pkg::pf_addr_t trans_addr_o,

  // Bus response, consumer always ready
  input  logic             resp_valid_i,

  // Fetch handshake
  input  logic             fetch_ready_i,
  output logic             fetch_valid_o,

  // External prefetch FIFO
  output logic             fifo_push_o,
  output logic             fifo_pop_o,
  output logic             fifo_flush_o,
  output logic             fifo_flush_but_first_o,
  input  pf_pkg::pf_cnt_t  fifo_cnt_i,
  input  logic             fifo_empty_i
);

  // Flow events seen by all three blocks
  pf_evt_if evt_if ();

  assign evt_if.branch     = branch_i;
  assign evt_if.hwlp_jump  = hwlp_jump_i;
  assign evt_if.resp_valid = resp_valid_i;

  // Admission and outstanding count
  pf_txn_tracker u_pf_txn_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .trans_ready_i (trans_ready_i),
    .fifo_cnt_i    (fifo_cnt_i),
    .trans_valid_o (trans_valid_o),
    .busy_o        (busy_o),
    .evt           (evt_if.tracker)
  );

  // Next transaction address
  pf_addr_gen u_pf_addr_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_addr_i (branch_addr_i),
    .hwlp_target_i (hwlp_target_i),
    .trans_addr_o  (trans_addr_o),
    .evt           (evt_if.addr)
  );

  // Speculative response discard and FIFO strobes
  pf_flush_ctrl u_pf_flush_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_ready_i          (fetch_ready_i),
    .fifo_empty_i           (fifo_empty_i),
    .fetch_valid_o          (fetch_valid_o),
    .fifo_push_o            (fifo_push_o),
    .fifo_pop_o             (fifo_pop_o),
    .fifo_flush_o           (fifo_flush_o),
    .fifo_flush_but_first_o (fifo_flush_but_first_o),
    .evt                    (evt_if.flush)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * Testbench clock and reset generator
 * 4 ns clock, active low reset held for 3 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 250 MHz
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the register updates
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_prefetch_ctrl.sv
/*
 * Testbench of the prefetch controller
 * Bus and FIFO models, LFSR stimulus, shadow reference model and checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "pf_cfg.svh"

module tb_prefetch_ctrl;
  import pf_pkg::*;

  localparam int N_CYCLES = 600;
  // Stimulus cycles plus reset and a margin
  localparam int TIMEOUT  = N_CYCLES + 3 + 40;

  logic     clk, rst_n;
  logic     req, branch, hwlp_jump, trans_ready, resp_valid, fetch_ready, fifo_empty;
  pf_addr_t branch_addr, hwlp_target, trans_addr;
  pf_cnt_t  fifo_cnt;
  logic     busy, trans_valid, fetch_valid, fifo_push, fifo_pop, fifo_flush, fifo_fbf;

  // Shadow state, values after the coming clock edge
  int       m_out, m_flush, m_dcnt, m_fifo;
  logic     m_wait, m_darm;
  pf_addr_t m_addr;
  // Due cycle of each accepted request, in order
  int       due_q[$];
  int       cyc;
  int       tick = 0;
  logic [15:0] lfsr_q;
  logic     exp_valid;
  pf_addr_t exp_addr;
  // fetch_valid, push, pop, flush, flush_but_first
  logic [4:0] exp_str;

  tb_clk_gen u_tb_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  pf_prefetch_ctrl u_pf_prefetch_ctrl (
    .clk (clk), .rst_n (rst_n), .req_i (req), .branch_i (branch),
    .branch_addr_i (branch_addr), .busy_o (busy), .hwlp_jump_i (hwlp_jump),
    .hwlp_target_i (hwlp_target), .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready), .trans_addr_o (trans_addr), .resp_valid_i (resp_valid),
    .fetch_ready_i (fetch_ready), .fetch_valid_o (fetch_valid), .fifo_push_o (fifo_push),
    .fifo_pop_o (fifo_pop), .fifo_flush_o (fifo_flush), .fifo_flush_but_first_o (fifo_fbf),
    .fifo_cnt_i (fifo_cnt), .fifo_empty_i (fifo_empty)
  );

  ////////////////////////////////////////////////////////////
  // Random source and compare
  ////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int unsigned v);
    v = 0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | lfsr_q[0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // FIFO words do not count during a branch or loop jump
  function automatic logic admission(input logic rq, input logic flow, input int fifo,
                                     input int out);
    return rq && (((flow ? 0 : fifo) + out) < `PF_DEPTH);
  endfunction

  function automatic pf_addr_t next_address(input logic br, input pf_addr_t baddr,
                                            input logic waiting, input logic jmp,
                                            input pf_addr_t target, input pf_addr_t last);
    pf_addr_t mask;
    mask = pf_addr_t'(`PF_WORD_BYTES - 1);
    if (br) return baddr & ~mask;
    // Held target is replayed until taken
    if (waiting) return last;
    if (jmp) return target;
    return last + `PF_WORD_BYTES;
  endfunction

  function automatic logic [4:0] fifo_strobes(input logic br, input logic jmp, input logic empty,
                                              input logic resp, input logic fready,
                                              input int flush);
    logic drop;
    logic pop;
    drop = br || (flush != 0);
    pop  = !empty && fready;
    return {(!empty || resp) && !drop, resp && (!empty || !fready) && !drop, pop,
            br || (jmp && !empty && pop), jmp && !empty && !pop};
  endfunction

  function automatic int flush_count_after(input logic br, input logic jmp, input logic empty,
                                           input logic resp, input int out, input int flush,
                                           input logic armed, input int dcnt);
    // Whole outstanding count, less a response dropped right now
    if (br || (jmp && (!empty || resp))) return resp ? out - 1 : out;
    if (armed && resp) return dcnt;
    if (resp && (flush != 0)) return flush - 1;
    return flush;
  endfunction

  ////////////////////////////////////////////////////////////
  // Per-cycle steps
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    int unsigned r;
    logic stall;
    // Periodic bus stall, branches pile up on a held target
    stall = (cyc % 50) >= 42;
    take_bits(2, r);
    trans_ready = stall ? 1'b0 : (r != 0);
    take_bits(2, r);
    fetch_ready = (r != 0);
    // Idle start, req low after reset
    take_bits(3, r);
    req = (cyc >= 8) && (r != 0);
    take_bits(stall ? 2 : 4, r);
    branch = (cyc >= 8) && (r == 0);
    take_bits(8, r);
    branch_addr = pf_addr_t'(32'h1000 + r);
    // Loop jump only when the loop end word is somewhere
    take_bits(4, r);
    hwlp_jump = (cyc >= 8) && (r == 0) && !branch && !m_wait && !m_darm && (m_flush == 0)
                && ((m_out != 0) || (m_fifo != 0));
    take_bits(6, r);
    hwlp_target = pf_addr_t'(32'h2000 + (r << 2));
    resp_valid = 1'b0;
    if (due_q.size() != 0) resp_valid = (due_q[0] <= cyc);
    fifo_cnt   = pf_cnt_t'(m_fifo);
    fifo_empty = (m_fifo == 0);
  endtask

  task automatic compare_outputs();
    exp_valid = admission(req, branch || hwlp_jump, m_fifo, m_out);
    exp_addr  = next_address(branch, branch_addr, m_wait, hwlp_jump, hwlp_target, m_addr);
    exp_str   = fifo_strobes(branch, hwlp_jump, fifo_empty, resp_valid, fetch_ready, m_flush);
    check_value("trans_valid_o", trans_valid, exp_valid);
    check_value("trans_addr_o", trans_addr, exp_addr);
    check_value("busy_o", busy, (m_out != 0) || exp_valid);
    check_value("fetch_valid_o", fetch_valid, exp_str[4]);
    check_value("fifo_push_o", fifo_push, exp_str[3]);
    check_value("fifo_pop_o", fifo_pop, exp_str[2]);
    check_value("fifo_flush_o", fifo_flush, exp_str[1]);
    check_value("fifo_flush_but_first_o", fifo_fbf, exp_str[0]);
  endtask

  task automatic advance_model();
    logic accept;
    int unsigned r;
    int due;
    accept  = exp_valid && trans_ready;
    m_flush = flush_count_after(branch, hwlp_jump, fifo_empty, resp_valid, m_out, m_flush,
                                m_darm, m_dcnt);
    // Delayed loop flush, a branch cancels it
    if (branch) begin
      m_darm = 1'b0;
    end else if (hwlp_jump && fifo_empty && !resp_valid) begin
      m_darm = 1'b1;
      m_dcnt = m_out - 1;
    end else if (m_darm && resp_valid) begin
      m_darm = 1'b0;
    end
    if (branch || hwlp_jump || accept) m_addr = exp_addr;
    m_wait = m_wait ? !accept : ((branch || hwlp_jump) && !accept);
    m_out  = m_out + int'(accept) - int'(resp_valid);
    // FIFO occupancy, a flush drops a push of the same cycle
    if (exp_str[1]) begin
      m_fifo = 0;
    end else if (exp_str[0]) begin
      m_fifo = 1;
    end else begin
      m_fifo = m_fifo + int'(exp_str[3]) - int'(exp_str[2]);
    end
    // Bus returns in order after 1 to 3 cycles
    if (resp_valid) void'(due_q.pop_front());
    if (accept) begin
      take_bits(2, r);
      due = cyc + 1 + int'(r % 3);
      if ((due_q.size() != 0) && (due <= due_q[$])) due = due_q[$] + 1;
      due_q.push_back(due);
    end
    if (m_fifo > `PF_DEPTH) begin
      $display("FIFO model holds %0d words, more than its depth", m_fifo);
      $display("TEST FAIL");
      $fatal(1, "FIFO overflow");
    end
  endtask

  initial begin
    lfsr_q = 16'd84;
    {req, branch, hwlp_jump, trans_ready, resp_valid, fetch_ready} = '0;
    fifo_empty  = 1'b1;
    fifo_cnt    = '0;
    branch_addr = '0;
    hwlp_target = '0;
    {m_out, m_flush, m_dcnt, m_fifo} = '0;
    {m_wait, m_darm} = '0;
    m_addr = '0;
    wait (rst_n === 1'b1);
    for (cyc = 0; cyc < N_CYCLES; cyc++) begin
      @(negedge clk);
      drive_inputs();
      // Mid-cycle, combinational outputs have settled
      #1;
      compare_outputs();
      advance_model();
    end
    $display("TEST PASS");
    $finish;
  end

  // Guard against a hung run
  always @(posedge clk) begin
    tick = tick + 1;
    if (tick >= TIMEOUT) begin
      $display("Run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
pf_pkg.sv
pf_evt_if.sv
pf_txn_tracker.sv
pf_addr_gen.sv
pf_flush_ctrl.sv
pf_prefetch_ctrl.sv
tb_clk_gen.sv
tb_prefetch_ctrl.sv
